/* memCtrlSettings.svh */
`ifndef MEM_CTRL_SETTINGS_SVH
`define MEM_CTRL_SETTINGS_SVH

// instruction and load/store word
`define MEM_WORD_W 32

// RAM data bus, one byte per cycle
`define MEM_BYTE_W 8

`define MEM_ADDR_W 32

// little-endian bytes on consecutive addresses
`define MEM_ADDR_STEP 1

// longest burst, a full word
`define MEM_MAX_BYTES 4

// length fields hold 0 to MEM_MAX_BYTES
`define MEM_LEN_W 3

`endif

/* memCtrlPkg.sv */
`include "memCtrlSettings.svh"

package memCtrlPkg;

    // controller states
    typedef enum logic [1:0] {
        Idle      = 2'd0,
        FetchRead = 2'd1,
        DataRead  = 2'd2,
        DataWrite = 2'd3
    } ctrlState_e;

    // data cache load/store select
    typedef enum logic {
        Load  = 1'b0,
        Store = 1'b1
    } accessKind_e;

    // lane 0 holds the byte at the base address
    typedef union packed {
        logic [`MEM_WORD_W-1:0]                     word;
        logic [`MEM_MAX_BYTES-1:0][`MEM_BYTE_W-1:0] lanes;
    } assembledWord_u;

endpackage

/* memArbiterFsm.sv */
`timescale 1ns/1ps
`include "memCtrlSettings.svh"

module memArbiterFsm
    import memCtrlPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_rdy,
    input  logic                   i_ioBufferFull,
    input  logic                   i_ifEn,
    input  logic [`MEM_ADDR_W-1:0] i_ifAddr,
    input  logic                   i_dcEn,
    input  accessKind_e            i_dcKind,
    input  logic [`MEM_LEN_W-1:0]  i_dcLen,
    input  logic [`MEM_ADDR_W-1:0] i_dcAddr,
    input  logic                   i_issueDone,
    input  logic                   i_returnDone,
    output ctrlState_e             o_state,
    output logic                   o_advance,
    output logic                   o_startAccess,
    output logic [`MEM_LEN_W-1:0]  o_accessLen,
    output logic [`MEM_ADDR_W-1:0] o_baseAddr,
    output logic                   o_memWr,
    output logic                   o_ifDone,
    output logic                   o_dcDone,
    output logic                   o_captureEn
);

    ctrlState_e state;
    logic       stall;
    logic       busy;
    logic       reading;
    logic       firstCycle;
    logic       finish;

    assign stall = !i_rdy || i_ioBufferFull;
    assign busy  = (state != Idle);

    assign o_state   = state;
    assign o_advance = busy && !stall;

    // the served requester still holds its enable during the done cycle
    assign o_startAccess = !busy && !stall && !o_ifDone && !o_dcDone && (i_ifEn || i_dcEn);

    assign reading = (state == FetchRead) || (state == DataRead);

    // writes go out only on non-stalled issue cycles
    assign o_memWr = (state == DataWrite) && o_advance;

    // nothing comes back in the first busy cycle
    assign o_captureEn = reading && o_advance && !firstCycle;

    // reads end on the last returned byte and writes on the last issued one
    assign finish = o_advance && (reading ? i_returnDone : i_issueDone);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= Idle;
            o_ifDone    <= 1'b0;
            o_dcDone    <= 1'b0;
            firstCycle  <= 1'b0;
            o_baseAddr  <= '0;
            o_accessLen <= '0;
        end else begin
            o_ifDone <= finish && (state == FetchRead);
            o_dcDone <= finish && (state != FetchRead);

            if (o_startAccess) begin
                firstCycle <= 1'b1;
                // data cache wins a tie
                if (i_dcEn) begin
                    state       <= (i_dcKind == Store) ? DataWrite : DataRead;
                    o_baseAddr  <= i_dcAddr;
                    o_accessLen <= i_dcLen;
                end else begin
                    state       <= FetchRead;
                    o_baseAddr  <= i_ifAddr;
                    o_accessLen <= `MEM_LEN_W'(`MEM_MAX_BYTES);
                end
            end else if (o_advance) begin
                firstCycle <= 1'b0;
                if (finish) begin
                    state <= Idle;
                end
            end
        end
    end

    // byte, half or word only
    property pDcLenLegal;
        @(posedge clk) disable iff (rst)
            (state == Idle) && i_dcEn |-> i_dcLen inside {1, 2, 4};
    endproperty

    assert property (pDcLenLegal)
        else $error("data cache length %0d is not 1, 2 or 4", i_dcLen);

endmodule

/* byteStageCounter.sv */
`timescale 1ns/1ps
`include "memCtrlSettings.svh"

module byteStageCounter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_startAccess,
    input  logic                  i_advance,
    input  logic [`MEM_LEN_W-1:0] i_accessLen,
    output logic [`MEM_LEN_W-1:0] o_issueIdx,
    output logic [`MEM_LEN_W-1:0] o_returnIdx,
    output logic                  o_issueDone,
    output logic                  o_returnDone
);

    logic [`MEM_LEN_W-1:0] issueCnt;
    logic [`MEM_LEN_W-1:0] heldIdx;
    logic [`MEM_LEN_W-1:0] lastIdx;
    logic                  issuing;
    logic                  returning;

    assign lastIdx = i_accessLen - 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            issueCnt    <= '0;
            heldIdx     <= '0;
            o_returnIdx <= '0;
            issuing     <= 1'b0;
            returning   <= 1'b0;
        end else begin
            // last presented index, repeated on the bus while stalled
            heldIdx <= o_issueIdx;
            if (i_startAccess) begin
                issueCnt    <= '0;
                o_returnIdx <= '0;
                issuing     <= 1'b1;
                returning   <= 1'b0;
            end else if (i_advance) begin
                // return side trails issue by the RAM latency
                returning   <= issuing;
                o_returnIdx <= issueCnt;
                if (issuing) begin
                    if (issueCnt == lastIdx) begin
                        issuing <= 1'b0;
                    end else begin
                        issueCnt <= issueCnt + 1'b1;
                    end
                end
            end
        end
    end

    // a stalled cycle shows the address of the cycle before
    assign o_issueIdx = i_advance ? issueCnt : heldIdx;

    assign o_issueDone  = issuing && (issueCnt == lastIdx);
    assign o_returnDone = returning && (o_returnIdx == lastIdx);

    property pReturnBehindIssue;
        @(posedge clk) disable iff (rst)
            o_returnIdx <= o_issueIdx;
    endproperty

    assert property (pReturnBehindIssue)
        else $error("return index %0d passed issue index %0d", o_returnIdx, o_issueIdx);

endmodule

/* loadAssembler.sv */
`timescale 1ns/1ps
`include "memCtrlSettings.svh"

module loadAssembler
    import memCtrlPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_captureEn,
    input  logic [`MEM_LEN_W-1:0]  i_returnIdx,
    input  logic [`MEM_BYTE_W-1:0] i_memDin,
    input  logic [`MEM_LEN_W-1:0]  i_accessLen,
    input  logic                   i_startAccess,
    output logic [`MEM_WORD_W-1:0] o_word
);

    localparam int LaneIdxW = $clog2(`MEM_MAX_BYTES);

    assembledWord_u gathered;
    assembledWord_u extended;

    // one returned byte per capture, little-endian lanes
    always_ff @(posedge clk) begin
        if (rst || i_startAccess) begin
            gathered.word <= '0;
        end else if (i_captureEn) begin
            gathered.lanes[i_returnIdx[LaneIdxW-1:0]] <= i_memDin;
        end
    end

    // zero extension above the access length
    always_comb begin
        extended.word = '0;
        for (int lane = 0; lane < `MEM_MAX_BYTES; lane++) begin
            if (lane < i_accessLen) begin
                extended.lanes[lane] = gathered.lanes[lane];
            end
        end
    end

    // fetches always fill all four lanes
    assign o_word = extended.word;

endmodule

/* storeSerializer.sv */
`timescale 1ns/1ps
`include "memCtrlSettings.svh"

module storeSerializer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_startAccess,
    input  logic [`MEM_WORD_W-1:0] i_storeData,
    input  logic [`MEM_LEN_W-1:0]  i_issueIdx,
    output logic [`MEM_BYTE_W-1:0] o_memDout
);

    localparam int LaneIdxW = $clog2(`MEM_MAX_BYTES);

    logic [`MEM_MAX_BYTES-1:0][`MEM_BYTE_W-1:0] storeBytes;

    // store word captured when the access is granted
    always_ff @(posedge clk) begin
        if (rst) begin
            storeBytes <= '0;
        end else if (i_startAccess) begin
            storeBytes <= i_storeData;
        end
    end

    // lsb first
    assign o_memDout = storeBytes[i_issueIdx[LaneIdxW-1:0]];

    property pIssueIdxInWord;
        @(posedge clk) disable iff (rst)
            i_issueIdx < `MEM_MAX_BYTES;
    endproperty

    assert property (pIssueIdxInWord)
        else $error("issue index %0d outside the store word", i_issueIdx);

endmodule

/* memCtrl.sv */
`timescale 1ns/1ps
`include "memCtrlSettings.svh"

module memCtrl
    import memCtrlPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_rdy,
    input  logic                   i_ioBufferFull,

    // byte RAM
    input  logic [`MEM_BYTE_W-1:0] i_memDin,
    output logic                   o_memWr,
    output logic [`MEM_ADDR_W-1:0] o_memAddr,
    output logic [`MEM_BYTE_W-1:0] o_memDout,

    // instruction fetch
    input  logic                   i_ifEn,
    input  logic [`MEM_ADDR_W-1:0] i_ifAddr,
    output logic                   o_ifDone,
    output logic [`MEM_WORD_W-1:0] o_ifInst,

    // data cache
    input  logic                   i_dcEn,
    input  accessKind_e            i_dcKind,
    input  logic [`MEM_LEN_W-1:0]  i_dcLen,
    input  logic [`MEM_ADDR_W-1:0] i_dcAddr,
    input  logic [`MEM_WORD_W-1:0] i_dcStoreData,
    output logic                   o_dcDone,
    output logic [`MEM_WORD_W-1:0] o_dcData
);

    ctrlState_e             state;
    logic                   advance;
    logic                   startAccess;
    logic                   captureEn;
    logic                   issueDone;
    logic                   returnDone;
    logic [`MEM_LEN_W-1:0]  accessLen;
    logic [`MEM_LEN_W-1:0]  issueIdx;
    logic [`MEM_LEN_W-1:0]  returnIdx;
    logic [`MEM_ADDR_W-1:0] baseAddr;
    logic [`MEM_WORD_W-1:0] loadWord;

    memArbiterFsm fsm (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_ifEn         (i_ifEn),
        .i_ifAddr       (i_ifAddr),
        .i_dcEn         (i_dcEn),
        .i_dcKind       (i_dcKind),
        .i_dcLen        (i_dcLen),
        .i_dcAddr       (i_dcAddr),
        .i_issueDone    (issueDone),
        .i_returnDone   (returnDone),
        .o_state        (state),
        .o_advance      (advance),
        .o_startAccess  (startAccess),
        .o_accessLen    (accessLen),
        .o_baseAddr     (baseAddr),
        .o_memWr        (o_memWr),
        .o_ifDone       (o_ifDone),
        .o_dcDone       (o_dcDone),
        .o_captureEn    (captureEn)
    );

    byteStageCounter stageCnt (
        .clk           (clk),
        .rst           (rst),
        .i_startAccess (startAccess),
        .i_advance     (advance),
        .i_accessLen   (accessLen),
        .o_issueIdx    (issueIdx),
        .o_returnIdx   (returnIdx),
        .o_issueDone   (issueDone),
        .o_returnDone  (returnDone)
    );

    loadAssembler assembler (
        .clk           (clk),
        .rst           (rst),
        .i_captureEn   (captureEn),
        .i_returnIdx   (returnIdx),
        .i_memDin      (i_memDin),
        .i_accessLen   (accessLen),
        .i_startAccess (startAccess),
        .o_word        (loadWord)
    );

    storeSerializer serializer (
        .clk           (clk),
        .rst           (rst),
        .i_startAccess (startAccess),
        .i_storeData   (i_dcStoreData),
        .i_issueIdx    (issueIdx),
        .o_memDout     (o_memDout)
    );

    assign o_memAddr = baseAddr + `MEM_ADDR_W'(issueIdx) * `MEM_ADDR_STEP;

    // valid while the matching done is high
    assign o_ifInst = loadWord;
    assign o_dcData = loadWord;

    // a stall mid-access keeps the RAM on the byte it is returning
    property pStallHoldsAddr;
        @(posedge clk) disable iff (rst)
            (state != Idle) && !advance && !$past(startAccess) |-> $stable(o_memAddr);
    endproperty

    assert property (pStallHoldsAddr)
        else $error("address moved during a stall, now %h", o_memAddr);

endmodule

/* tbRamModel.sv */
`timescale 1ns/1ps
`include "memCtrlSettings.svh"

module tbRamModel #(
    parameter int Depth = 256
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`MEM_ADDR_W-1:0] i_addr,
    input  logic                   i_wr,
    input  logic [`MEM_BYTE_W-1:0] i_din,
    output logic [`MEM_BYTE_W-1:0] o_dout
);

    localparam int IdxW = $clog2(Depth);

    logic [`MEM_BYTE_W-1:0] mem [0:Depth-1];
    logic [IdxW-1:0]        idx;

    // small model, upper address bits ignored
    assign idx = i_addr[IdxW-1:0];

    initial begin
        o_dout = '0;
    end

    // one cycle read latency, old byte on a write
    always @(posedge clk) begin
        if (i_wr) begin
            mem[idx] <= i_din;
        end
        if (rst) begin
            o_dout <= '0;
        end else begin
            o_dout <= mem[idx];
        end
    end

endmodule

/* tb_memCtrl.sv */
`timescale 1ns/1ps
`include "memCtrlSettings.svh"

module tb_memCtrl
    import memCtrlPkg::*;
();

    localparam int MemDepth  = 256;
    localparam int WaitLimit = 300;

    logic                   clk;
    logic                   rst;
    logic                   rdy;
    logic                   ioBufferFull;
    logic [`MEM_BYTE_W-1:0] memDin;
    logic                   memWr;
    logic [`MEM_ADDR_W-1:0] memAddr;
    logic [`MEM_BYTE_W-1:0] memDout;
    logic                   ifEn;
    logic [`MEM_ADDR_W-1:0] ifAddr;
    logic                   ifDone;
    logic [`MEM_WORD_W-1:0] ifInst;
    logic                   dcEn;
    accessKind_e            dcKind;
    logic [`MEM_LEN_W-1:0]  dcLen;
    logic [`MEM_ADDR_W-1:0] dcAddr;
    logic [`MEM_WORD_W-1:0] dcStoreData;
    logic                   dcDone;
    logic [`MEM_WORD_W-1:0] dcData;

    // reference memory and checker state
    logic [`MEM_BYTE_W-1:0] refMem [0:MemDepth-1];
    logic [`MEM_WORD_W-1:0] expIf;
    logic [`MEM_WORD_W-1:0] expDc;
    logic                   stallsOn;
    logic                   anyReq;
    logic                   timeFetch;
    logic                   tieCheck;
    logic [31:0]            cycleNo;
    logic [31:0]            launchCycle;
    logic [31:0]            wrCount;
    logic [31:0]            wrTarget;
    logic [31:0]            dcDoneCnt;
    logic [31:0]            tieMark;
    logic [31:0]            stimRng;
    logic [31:0]            stallRng;

    always #4 clk = ~clk;

    memCtrl uut (
        .clk(clk), .rst(rst), .i_rdy(rdy), .i_ioBufferFull(ioBufferFull),
        .i_memDin(memDin), .o_memWr(memWr), .o_memAddr(memAddr), .o_memDout(memDout),
        .i_ifEn(ifEn), .i_ifAddr(ifAddr), .o_ifDone(ifDone), .o_ifInst(ifInst),
        .i_dcEn(dcEn), .i_dcKind(dcKind), .i_dcLen(dcLen), .i_dcAddr(dcAddr),
        .i_dcStoreData(dcStoreData), .o_dcDone(dcDone), .o_dcData(dcData)
    );

    tbRamModel #(.Depth(MemDepth)) ram (
        .clk(clk), .rst(rst), .i_addr(memAddr), .i_wr(memWr), .i_din(memDout), .o_dout(memDin)
    );

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // little-endian bytes from the reference, zero above len
    function automatic logic [31:0] expectedWord(input logic [31:0] addr, input int len);
        logic [31:0] w;
        w = '0;
        for (int b = 0; b < len; b++) begin
            w[8*b +: 8] = refMem[addr + b];
        end
        return w;
    endfunction

    function automatic int pickLen(input logic [31:0] r);
        case (r % 3)
            0:       return 1;
            1:       return 2;
            default: return 4;
        endcase
    endfunction

    task automatic stopOnFailure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic valueError(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        stopOnFailure($sformatf("Error at time %0t: %s expected %h, got %h",
                                $time, name, expected, actual));
    endtask

    always @(posedge clk) begin
        cycleNo <= cycleNo + 1;
        if (rst) begin
            wrCount   <= '0;
            dcDoneCnt <= '0;
        end else begin
            wrCount   <= wrCount + memWr;
            dcDoneCnt <= dcDoneCnt + dcDone;
        end
    end

    // random back-pressure from either source
    always @(posedge clk) begin
        if (stallsOn) begin
            stallRng = nextRandom(stallRng);
            rdy          <= (stallRng[2:0] != 3'd0);
            ioBufferFull <= (stallRng[5:3] == 3'd0);
        end else begin
            rdy          <= 1'b1;
            ioBufferFull <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !anyReq |-> !ifDone && !dcDone && !memWr)
        else stopOnFailure("a done or write strobe was raised before any request");
    assert property (@(posedge clk) disable iff (rst) ifDone |-> ifInst == expIf)
        else valueError("o_ifInst", $sampled(expIf), $sampled(ifInst));
    assert property (@(posedge clk) disable iff (rst) dcDone && dcKind == Load |-> dcData == expDc)
        else valueError("o_dcData", $sampled(expDc), $sampled(dcData));
    // request driven at edge L, accepted at L+1, done sampled at L+7
    assert property (@(posedge clk) disable iff (rst)
        timeFetch && ifDone |-> cycleNo - launchCycle == 32'd7)
        else valueError("o_ifDone latency", 32'd7, $sampled(cycleNo - launchCycle));
    assert property (@(posedge clk) disable iff (rst)
        dcDone && dcKind == Store |-> wrCount == wrTarget)
        else valueError("o_memWr count", $sampled(wrTarget), $sampled(wrCount));
    assert property (@(posedge clk) disable iff (rst) !rdy || ioBufferFull |-> !memWr)
        else stopOnFailure("a RAM write was issued during a stall cycle");
    assert property (@(posedge clk) disable iff (rst) tieCheck && ifDone |-> dcDoneCnt != tieMark)
        else stopOnFailure("the fetch finished before the data cache on a tie");

    task automatic driveFetch(input logic [31:0] addr, input logic timed);
        ifEn        <= 1'b1;
        ifAddr      <= addr;
        expIf       <= expectedWord(addr, 4);
        launchCycle <= cycleNo;
        timeFetch   <= timed;
        anyReq      <= 1'b1;
    endtask

    task automatic driveData(input accessKind_e kind, input int len,
                             input logic [31:0] addr, input logic [31:0] data);
        dcEn        <= 1'b1;
        dcKind      <= kind;
        dcLen       <= `MEM_LEN_W'(len);
        dcAddr      <= addr;
        dcStoreData <= data;
        anyReq      <= 1'b1;
        if (kind == Store) begin
            for (int b = 0; b < len; b++) begin
                refMem[addr + b] = data[8*b +: 8];
            end
            wrTarget <= wrCount + len;
        end else begin
            expDc <= expectedWord(addr, len);
        end
    endtask

    task automatic waitFetchDone();
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < WaitLimit && !seen; n++) begin
            @(posedge clk);
            seen = ifDone;
        end
        if (!seen) begin
            stopOnFailure("fetch done never arrived within the timeout");
        end else begin
            ifEn      <= 1'b0;
            timeFetch <= 1'b0;
            tieCheck  <= 1'b0;
        end
    endtask

    task automatic waitDataDone();
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < WaitLimit && !seen; n++) begin
            @(posedge clk);
            seen = dcDone;
        end
        if (!seen) begin
            stopOnFailure("data cache done never arrived within the timeout");
        end else begin
            dcEn <= 1'b0;
        end
    endtask

    task automatic runFetch(input logic [31:0] addr, input logic timed);
        @(posedge clk);
        driveFetch(addr, timed);
        waitFetchDone();
    endtask

    task automatic runData(input accessKind_e kind, input int len,
                           input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        driveData(kind, len, addr, data);
        waitDataDone();
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        int          len;
        clk = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        ifEn = 1'b0;
        ifAddr = '0;
        dcEn = 1'b0;
        dcKind = Load;
        dcLen = `MEM_LEN_W'(1);
        dcAddr = '0;
        dcStoreData = '0;
        {stallsOn, anyReq, timeFetch, tieCheck} = '0;
        {cycleNo, launchCycle, wrTarget, tieMark, expIf, expDc} = '0;
        stimRng  = 32'h2e59_ead2;
        stallRng = {stimRng[15:0], stimRng[31:16]};
        // odd multiplier keeps every byte address distinct
        for (int a = 0; a < MemDepth; a++) begin
            refMem[a]  = 8'(a * 37 + 8'h6b);
            ram.mem[a] = 8'(a * 37 + 8'h6b);
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);

        runFetch(32'h40, 1'b1);

        // each length, read, write, read back
        for (int i = 0; i < 3; i++) begin
            stimRng = nextRandom(stimRng);
            addr    = stimRng % 252;
            data    = nextRandom(stimRng);
            runData(Load, 1 << i, addr, '0);
            runData(Store, 1 << i, addr, data);
            runData(Load, 1 << i, addr, '0);
        end

        // both requesters in the same idle cycle
        @(posedge clk);
        driveData(Store, 4, 32'h80, 32'hc0de_1234);
        driveFetch(32'h80, 1'b0);
        tieMark  <= dcDoneCnt;
        tieCheck <= 1'b1;
        waitDataDone();
        waitFetchDone();

        @(posedge clk);
        stallsOn <= 1'b1;
        repeat (40) begin
            stimRng = nextRandom(stimRng);
            addr    = stimRng % 252;
            len     = pickLen(stimRng >> 8);
            data    = nextRandom(stimRng);
            case (stimRng[17:16])
                2'd0: runFetch(addr, 1'b0);
                2'd1: runData(Load, len, addr, '0);
                default: begin
                    runData(Store, len, addr, data);
                    runData(Load, len, addr, '0);
                end
            endcase
        end
        @(posedge clk);
        stallsOn <= 1'b0;
        repeat (4) @(posedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

/* list.f */
+incdir+.
memCtrlPkg.sv
memArbiterFsm.sv
byteStageCounter.sv
loadAssembler.sv
storeSerializer.sv
memCtrl.sv
tbRamModel.sv
tb_memCtrl.sv
